// File: rtl/squeeze_pkg.sv
package squeeze_pkg;

	////////////////////////////////////////////////////////////////////////////
	// Datapath widths
	////////////////////////////////////////////////////////////////////////////

	// Pixel, weight and output value
	localparam int PIX_W = 16;
	// Accumulator and bias
	localparam int ACC_W = 32;
	// Requantization shift, Q14 products back to pixel scale
	localparam int FRAC_SHIFT = 14;

	// Side band that rides along with each registered pixel
	typedef struct packed {
		logic valid;   // pixel accepted this cycle
		logic last;    // pixel closes an output pixel
	} tap_ctrl_t;

	// Layer sequencer states
	typedef enum logic {
		SEQ_RUN  = 1'b0,
		SEQ_DONE = 1'b1
	} seq_state_t;

	////////////////////////////////////////////////////////////////////////////
	// Coefficient rule, shared by the ROM and the reference model
	////////////////////////////////////////////////////////////////////////////

	// Small signed weight, roughly +-2^10, from a hash of tap and lane
	function automatic logic signed [PIX_W-1:0] coeff_weight(input int tap, input int lane);
		int h;
		h = ((tap * 73) ^ (lane * 151)) + tap * lane * 11 + 29;
		h = h % 2047;
		return PIX_W'(h - 1023);
	endfunction

	// Per lane bias; every fourth lane gets a large offset so the slice wraps
	function automatic logic signed [ACC_W-1:0] coeff_bias(input int lane);
		int h;
		h = (lane * 977 + 311) % 4001;
		h = (h - 2000) * 2048;
		if (lane % 4 == 3)
			h = h + 536870912;
		return ACC_W'(h);
	endfunction

endpackage

// File: rtl/coeff_rom.sv
`timescale 1ns/1ps

module coeff_rom #(
	parameter int LANES = 8,
	parameter int TAPS  = 18
) (
	input  logic                                       clk,
	input  logic [$clog2(TAPS)-1:0]                    tap_addr,
	output logic [LANES-1:0][squeeze_pkg::PIX_W-1:0]   weights,
	output logic [LANES-1:0][squeeze_pkg::ACC_W-1:0]   biases
);

	// One ROM word per tap, holding the weights of all lanes
	typedef logic [TAPS-1:0][LANES-1:0][squeeze_pkg::PIX_W-1:0] rom_t;
	typedef logic [LANES-1:0][squeeze_pkg::ACC_W-1:0] bias_t;

	////////////////////////////////////////////////////////////////////////////
	// Table build at elaboration
	////////////////////////////////////////////////////////////////////////////

	function automatic rom_t build_rom();
		rom_t t;
		for (int a = 0; a < TAPS; a++) begin
			for (int l = 0; l < LANES; l++) begin
				t[a][l] = squeeze_pkg::coeff_weight(a, l);
			end
		end
		return t;
	endfunction

	function automatic bias_t build_bias();
		bias_t b;
		for (int l = 0; l < LANES; l++) begin
			b[l] = squeeze_pkg::coeff_bias(l);
		end
		return b;
	endfunction

	localparam rom_t  ROM  = build_rom();
	localparam bias_t BIAS = build_bias();

	// Registered read, one cycle latency
	// Lines up with the pixel register in the sequencer
	always_ff @(posedge clk) begin
		weights <= ROM[tap_addr];
	end

	// Biases are constant for the whole layer
	assign biases = BIAS;

endmodule

// File: rtl/layer_sequencer.sv
`timescale 1ns/1ps

module layer_sequencer #(
	parameter int TAPS       = 18,
	parameter int OUT_PIXELS = 16
) (
	input  logic                                  clk,
	input  logic                                  rst,
	input  logic                                  layer_en,
	input  logic signed [squeeze_pkg::PIX_W-1:0]  ifm,
	input  logic                                  ofm_sample,
	input  logic                                  ram_feedback,
	output logic [$clog2(TAPS)-1:0]               tap_addr,
	output logic signed [squeeze_pkg::PIX_W-1:0]  pix_d,
	output squeeze_pkg::tap_ctrl_t                tap_ctrl,
	output logic                                  layer_finish
);

	localparam int TAP_W  = $clog2(TAPS);
	localparam int SAMP_W = $clog2(OUT_PIXELS + 1);
	localparam logic [TAP_W-1:0]  LAST_TAP    = TAP_W'(TAPS - 1);
	localparam logic [SAMP_W-1:0] LAST_SAMPLE = SAMP_W'(OUT_PIXELS - 1);

	squeeze_pkg::seq_state_t state;
	logic [TAP_W-1:0]        tap_cnt;
	logic [SAMP_W-1:0]       samp_cnt;
	logic                    accept;
	logic                    last_tap;
	logic                    fb_seen;

	// Pixel taken only while the layer still runs
	assign accept   = layer_en && (state == squeeze_pkg::SEQ_RUN);
	assign last_tap = (tap_cnt == LAST_TAP);

	////////////////////////////////////////////////////////////////////////////
	// Tap counter
	////////////////////////////////////////////////////////////////////////////

	// Holds on idle cycles, so a window may span gaps
	always_ff @(posedge clk) begin
		if (rst) begin
			tap_cnt <= '0;
		end else if (accept) begin
			if (last_tap)
				tap_cnt <= '0;
			else
				tap_cnt <= tap_cnt + 1'b1;
		end
	end

	// ROM address is the tap of the pixel on ifm now
	assign tap_addr = tap_cnt;

	// Pixel register, same stage as the ROM output
	always_ff @(posedge clk) begin
		if (accept)
			pix_d <= ifm;
	end

	// Control travels with the registered pixel
	always_ff @(posedge clk) begin
		if (rst) begin
			tap_ctrl <= '0;
		end else begin
			tap_ctrl.valid <= accept;
			tap_ctrl.last  <= accept && last_tap;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Layer end and finish handshake
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (rst) begin
			samp_cnt <= '0;
			state    <= squeeze_pkg::SEQ_RUN;
		end else if (state == squeeze_pkg::SEQ_RUN && ofm_sample) begin
			samp_cnt <= samp_cnt + 1'b1;
			// Last output pixel of the layer
			if (samp_cnt == LAST_SAMPLE)
				state <= squeeze_pkg::SEQ_DONE;
		end
	end

	// Sticky, an early pulse also counts
	always_ff @(posedge clk) begin
		if (rst)
			fb_seen <= 1'b0;
		else if (ram_feedback)
			fb_seen <= 1'b1;
	end

	assign layer_finish = (state == squeeze_pkg::SEQ_DONE) && !fb_seen;

	// A valid pixel always comes from a cycle in which the layer still ran
	a_no_valid_after_done: assert property (@(posedge clk) disable iff (rst)
		tap_ctrl.valid |-> ($past(state) == squeeze_pkg::SEQ_RUN));

endmodule

// File: rtl/mac_lane.sv
`timescale 1ns/1ps

module mac_lane (
	input  logic                                  clk,
	input  logic                                  rst,
	input  squeeze_pkg::tap_ctrl_t                tap_ctrl,
	input  logic signed [squeeze_pkg::PIX_W-1:0]  pix,
	input  logic signed [squeeze_pkg::PIX_W-1:0]  ker,
	output logic signed [squeeze_pkg::ACC_W-1:0]  acc_out,
	output logic                                  sum_valid
);

	logic signed [squeeze_pkg::ACC_W-1:0] prod;
	logic signed [squeeze_pkg::ACC_W-1:0] acc;
	logic signed [squeeze_pkg::ACC_W-1:0] acc_next;

	// Full precision 16x16 product
	assign prod     = pix * ker;
	assign acc_next = acc + prod;

	// Running sum of the current window
	always_ff @(posedge clk) begin
		if (rst) begin
			acc <= '0;
		end else if (tap_ctrl.valid) begin
			// Restart right after the closing tap
			if (tap_ctrl.last)
				acc <= '0;
			else
				acc <= acc_next;
		end
	end

	// Completed window, held until the next one
	always_ff @(posedge clk) begin
		if (tap_ctrl.valid && tap_ctrl.last)
			acc_out <= acc_next;
	end

	always_ff @(posedge clk) begin
		if (rst)
			sum_valid <= 1'b0;
		else
			sum_valid <= tap_ctrl.valid && tap_ctrl.last;
	end

	// Sequencer marks last only on accepted pixels
	a_last_needs_valid: assert property (@(posedge clk) disable iff (rst)
		tap_ctrl.last |-> tap_ctrl.valid);

endmodule

// File: rtl/requant_relu.sv
`timescale 1ns/1ps

module requant_relu #(
	parameter int LANES = 8
) (
	input  logic                                      clk,
	input  logic                                      rst,
	input  logic                                      sum_valid,
	input  logic [LANES-1:0][squeeze_pkg::ACC_W-1:0]  sums,
	input  logic [LANES-1:0][squeeze_pkg::ACC_W-1:0]  biases,
	output logic [LANES-1:0][squeeze_pkg::PIX_W-1:0]  ofm,
	output logic                                      ofm_sample
);

	// Slice bounds inside the biased sum
	localparam int SLICE_LO = squeeze_pkg::FRAC_SHIFT;
	localparam int SLICE_HI = squeeze_pkg::FRAC_SHIFT + squeeze_pkg::PIX_W - 2;
	localparam int SIGN_BIT = squeeze_pkg::ACC_W - 1;

	logic [LANES-1:0][squeeze_pkg::ACC_W-1:0] biased;

	////////////////////////////////////////////////////////////////////////////
	// Bias, ReLU and requantization
	////////////////////////////////////////////////////////////////////////////

	// 32-bit add, overflow wraps
	always_comb begin
		for (int i = 0; i < LANES; i++) begin
			biased[i] = sums[i] + biases[i];
		end
	end

	// Negative clamps to zero
	// Bits above SLICE_HI are dropped, large sums wrap
	always_ff @(posedge clk) begin
		if (sum_valid) begin
			for (int i = 0; i < LANES; i++) begin
				if (biased[i][SIGN_BIT])
					ofm[i] <= '0;
				else
					ofm[i] <= {1'b0, biased[i][SLICE_HI:SLICE_LO]};
			end
		end
	end

	// Strobe, one cycle after the sums
	always_ff @(posedge clk) begin
		if (rst)
			ofm_sample <= 1'b0;
		else
			ofm_sample <= sum_valid;
	end

	// Back to back strobes only follow back to back sums
	a_strobe_spacing: assert property (@(posedge clk) disable iff (rst)
		(ofm_sample && $past(ofm_sample)) |-> ($past(sum_valid) && $past(sum_valid, 2)));

endmodule

// File: rtl/squeeze_layer.sv
`timescale 1ns/1ps

module squeeze_layer #(
	parameter int LANES      = 8,
	parameter int TAPS       = 18,
	parameter int OUT_PIXELS = 16
) (
	input  logic                                      clk,
	input  logic                                      rst,
	input  logic                                      layer_en,
	input  logic signed [squeeze_pkg::PIX_W-1:0]      ifm,
	input  logic                                      ram_feedback,
	output logic [LANES-1:0][squeeze_pkg::PIX_W-1:0]  ofm,
	output logic                                      ofm_sample,
	output logic                                      layer_finish
);

	logic [$clog2(TAPS)-1:0]                   tap_addr;
	logic signed [squeeze_pkg::PIX_W-1:0]      pix_d;
	squeeze_pkg::tap_ctrl_t                    tap_ctrl;
	logic [LANES-1:0][squeeze_pkg::PIX_W-1:0]  weights;
	logic [LANES-1:0][squeeze_pkg::ACC_W-1:0]  biases;
	logic [LANES-1:0][squeeze_pkg::ACC_W-1:0]  sums;
	// All lanes pulse together, lane 0 stands for the array
	logic [LANES-1:0]                          lane_valid;

	////////////////////////////////////////////////////////////////////////////
	// Control and coefficients
	////////////////////////////////////////////////////////////////////////////

	layer_sequencer #(
		.TAPS       (TAPS),
		.OUT_PIXELS (OUT_PIXELS)
	) layer_sequencer_i (
		.clk          (clk),
		.rst          (rst),
		.layer_en     (layer_en),
		.ifm          (ifm),
		.ofm_sample   (ofm_sample),
		.ram_feedback (ram_feedback),
		.tap_addr     (tap_addr),
		.pix_d        (pix_d),
		.tap_ctrl     (tap_ctrl),
		.layer_finish (layer_finish)
	);

	coeff_rom #(
		.LANES (LANES),
		.TAPS  (TAPS)
	) coeff_rom_i (
		.clk      (clk),
		.tap_addr (tap_addr),
		.weights  (weights),
		.biases   (biases)
	);

	////////////////////////////////////////////////////////////////////////////
	// MAC array and output stage
	////////////////////////////////////////////////////////////////////////////

	// One lane per output channel, same pixel to all
	for (genvar g = 0; g < LANES; g++) begin : g_lane
		mac_lane mac_lane_i (
			.clk       (clk),
			.rst       (rst),
			.tap_ctrl  (tap_ctrl),
			.pix       (pix_d),
			.ker       (weights[g]),
			.acc_out   (sums[g]),
			.sum_valid (lane_valid[g])
		);
	end

	requant_relu #(
		.LANES (LANES)
	) requant_relu_i (
		.clk        (clk),
		.rst        (rst),
		.sum_valid  (lane_valid[0]),
		.sums       (sums),
		.biases     (biases),
		.ofm        (ofm),
		.ofm_sample (ofm_sample)
	);

endmodule

// File: tb/squeeze_checker.sv
`timescale 1ns/1ps

module squeeze_checker #(
	parameter int LANES      = 8,
	parameter int TAPS       = 18,
	parameter int OUT_PIXELS = 16
) (
	input  logic                                      clk,
	input  logic                                      rst,
	input  logic                                      layer_en,
	input  logic signed [squeeze_pkg::PIX_W-1:0]      ifm,
	input  logic                                      ram_feedback,
	input  logic [LANES-1:0][squeeze_pkg::PIX_W-1:0]  ofm,
	input  logic                                      ofm_sample,
	input  logic                                      layer_finish,
	output int                                        samples,
	output int                                        value_errs,
	output int                                        ctrl_errs,
	output int                                        relu_zeros,
	output int                                        slice_wraps,
	output int                                        gap_windows
);

	localparam int PW       = squeeze_pkg::PIX_W;
	// Lowest bit above the output slice
	localparam int TOP_DROP = squeeze_pkg::FRAC_SHIFT + PW - 1;

	typedef logic [LANES-1:0][PW-1:0] ofm_vec_t;

	// Windows closed by the model, oldest first
	ofm_vec_t exp_q[$];
	int acc[LANES];
	int tap   = 0;
	int samp  = 0;
	int run   = 1;
	int verr  = 0;
	int cerr  = 0;
	int zeros = 0;
	int wraps = 0;
	int gaps  = 0;
	bit gap    = 1'b0;
	bit done_m = 1'b0;
	bit fb_m   = 1'b0;
	bit rst_d  = 1'b0;

	// Negative clamps to 0, else 15 bits above the fraction
	function automatic logic [PW-1:0] requant(input logic [31:0] biased);
		if (biased[31])
			return '0;
		return PW'((biased >> squeeze_pkg::FRAC_SHIFT) & ((32'd1 << (PW - 1)) - 1));
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// Reference model on pre-edge values
	////////////////////////////////////////////////////////////////////////////

	always @(posedge clk) begin : model
		logic [31:0] biased;
		ofm_vec_t    exp_v;
		ofm_vec_t    got_v;
		bit          accept;
		bit          exp_fin;
		if (rst) begin
			// Reset after a run that produced samples opens the next run
			if (!rst_d && samp != 0)
				run++;
			// Finish must be low from the second reset cycle on
			if (rst_d && layer_finish !== 1'b0) begin
				$display("layer_finish is high during reset before run %0d", run);
				cerr++;
			end
			exp_q.delete();
			tap    = 0;
			samp   = 0;
			gap    = 1'b0;
			done_m = 1'b0;
			fb_m   = 1'b0;
			for (int l = 0; l < LANES; l++)
				acc[l] = 0;
		end else begin
			// Finish level from the state before this edge
			exp_fin = done_m && !fb_m;
			if (layer_finish !== exp_fin) begin
				$display("error layer_finish run %0d expected %b actual %b",
					run, exp_fin, layer_finish);
				cerr++;
			end
			// Pixel accepted until OUT_PIXELS strobes were seen
			accept = layer_en && (samp < OUT_PIXELS);
			if (accept) begin
				for (int l = 0; l < LANES; l++)
					acc[l] = acc[l] + int'(ifm) * int'(squeeze_pkg::coeff_weight(tap, l));
				if (tap == TAPS - 1) begin
					for (int l = 0; l < LANES; l++) begin
						biased = acc[l] + squeeze_pkg::coeff_bias(l);
						if (biased[31])
							zeros++;
						else if ((biased >> TOP_DROP) != 0)
							wraps++;
						exp_v[l] = requant(biased);
						acc[l] = 0;
					end
					exp_q.push_back(exp_v);
					if (gap)
						gaps++;
					gap = 1'b0;
					tap = 0;
				end else begin
					tap++;
				end
			end else if (tap != 0) begin
				// Idle cycle inside an open window
				gap = 1'b1;
			end
			if (ofm_sample) begin
				got_v = ofm;
				if (exp_q.size() == 0) begin
					$display("ofm_sample came with no complete window in run %0d", run);
					cerr++;
				end else begin
					exp_v = exp_q.pop_front();
					for (int l = 0; l < LANES; l++) begin
						if (got_v[l] !== exp_v[l]) begin
							$display("error ofm_value run %0d sample %0d lane %0d expected %h actual %h",
								run, samp, l, exp_v[l], got_v[l]);
							verr++;
						end
					end
				end
				samp++;
				if (samp == OUT_PIXELS)
					done_m = 1'b1;
			end
			// Sticky since reset
			if (ram_feedback)
				fb_m = 1'b1;
		end
		rst_d = rst;
		samples     <= samp;
		value_errs  <= verr;
		ctrl_errs   <= cerr;
		relu_zeros  <= zeros;
		slice_wraps <= wraps;
		gap_windows <= gaps;
	end

endmodule

// File: tb/tb_squeeze_layer.sv
`timescale 1ns/1ps

module tb_squeeze_layer;

	localparam int LANES          = 8;
	localparam int TAPS           = 18;
	localparam int OUT_PIXELS     = 16;
	localparam int END_TIMEOUT    = 4000;
	localparam int FINISH_TIMEOUT = 20;
	localparam int AFTER_END      = 40;

	logic                                      clk = 1'b0;
	logic                                      rst;
	logic                                      layer_en;
	logic signed [squeeze_pkg::PIX_W-1:0]      ifm;
	logic                                      ram_feedback;
	logic [LANES-1:0][squeeze_pkg::PIX_W-1:0]  ofm;
	logic                                      ofm_sample;
	logic                                      layer_finish;

	// Checker results
	int samples;
	int value_errs;
	int ctrl_errs;
	int relu_zeros;
	int slice_wraps;
	int gap_windows;

	int          run_errs   = 0;
	bit          timed_out  = 1'b0;
	logic [31:0] rand_state = 32'd39;

	// 8 ns period
	always #4 clk = ~clk;

	squeeze_layer #(
		.LANES      (LANES),
		.TAPS       (TAPS),
		.OUT_PIXELS (OUT_PIXELS)
	) squeeze_layer_i (
		.clk          (clk),
		.rst          (rst),
		.layer_en     (layer_en),
		.ifm          (ifm),
		.ram_feedback (ram_feedback),
		.ofm          (ofm),
		.ofm_sample   (ofm_sample),
		.layer_finish (layer_finish)
	);

	squeeze_checker #(
		.LANES      (LANES),
		.TAPS       (TAPS),
		.OUT_PIXELS (OUT_PIXELS)
	) squeeze_checker_i (
		.clk          (clk),
		.rst          (rst),
		.layer_en     (layer_en),
		.ifm          (ifm),
		.ram_feedback (ram_feedback),
		.ofm          (ofm),
		.ofm_sample   (ofm_sample),
		.layer_finish (layer_finish),
		.samples      (samples),
		.value_errs   (value_errs),
		.ctrl_errs    (ctrl_errs),
		.relu_zeros   (relu_zeros),
		.slice_wraps  (slice_wraps),
		.gap_windows  (gap_windows)
	);

	////////////////////////////////////////////////////////////////////////////
	// Stimulus helpers
	////////////////////////////////////////////////////////////////////////////

	function automatic logic [31:0] next_rand();
		rand_state = rand_state * 32'd1664525 + 32'd1013904223;
		return rand_state;
	endfunction

	// Enable about 3 of 4 cycles, pixel within +-2^11
	task automatic drive_pixel(input bit random_fb);
		logic [31:0] r;
		r = next_rand();
		layer_en     <= (r[31:30] != 2'b00);
		ifm          <= {{4{r[27]}}, r[27:16]};
		ram_feedback <= random_fb && (r[13:8] == 6'd0);
	endtask

	task automatic apply_reset();
		@(posedge clk);
		rst          <= 1'b1;
		layer_en     <= 1'b0;
		ifm          <= '0;
		ram_feedback <= 1'b0;
		repeat (16) @(posedge clk);
		rst <= 1'b0;
	endtask

	task automatic offer_until_end(input bit random_fb, output bit ok);
		ok = 1'b0;
		for (int cyc = 0; cyc < END_TIMEOUT && !ok; cyc++) begin
			@(posedge clk);
			if (samples == OUT_PIXELS)
				ok = 1'b1;
			drive_pixel(random_fb);
		end
	endtask

	task automatic wait_finish_level(input logic level, output bit ok);
		ok = 1'b0;
		for (int cyc = 0; cyc < FINISH_TIMEOUT && !ok; cyc++) begin
			@(posedge clk);
			if (layer_finish === level)
				ok = 1'b1;
			drive_pixel(1'b0);
		end
	endtask

	// Pixels offered after the layer ended
	task automatic offer_after_end(input int cycles);
		repeat (cycles) begin
			@(posedge clk);
			drive_pixel(1'b0);
		end
	endtask

	task automatic pulse_feedback();
		@(posedge clk);
		drive_pixel(1'b0);
		ram_feedback <= 1'b1;
		@(posedge clk);
		drive_pixel(1'b0);
	endtask

	task automatic check_strobe_count(input int run);
		if (samples != OUT_PIXELS) begin
			$display("error strobe_count run %0d expected %0d actual %0d",
				run, OUT_PIXELS, samples);
			run_errs++;
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Test sequence
	////////////////////////////////////////////////////////////////////////////

	task automatic run_all();
		bit ok;
		// Run 1, feedback only after the end
		apply_reset();
		offer_until_end(1'b0, ok);
		if (!ok) begin
			$display("timeout: run 1 did not produce all output pixels");
			timed_out = 1'b1;
			return;
		end
		wait_finish_level(1'b1, ok);
		if (!ok) begin
			$display("timeout: layer_finish did not rise after the last sample");
			timed_out = 1'b1;
			return;
		end
		offer_after_end(AFTER_END);
		pulse_feedback();
		wait_finish_level(1'b0, ok);
		if (!ok) begin
			$display("timeout: layer_finish did not fall after ram_feedback");
			timed_out = 1'b1;
			return;
		end
		offer_after_end(AFTER_END);
		check_strobe_count(1);
		// Run 2, early and random feedback
		apply_reset();
		pulse_feedback();
		offer_until_end(1'b1, ok);
		if (!ok) begin
			$display("timeout: run 2 did not produce all output pixels");
			timed_out = 1'b1;
			return;
		end
		offer_after_end(AFTER_END);
		check_strobe_count(2);
	endtask

	initial begin
		rst          = 1'b1;
		layer_en     = 1'b0;
		ifm          = '0;
		ram_feedback = 1'b0;
		run_all();
		@(negedge clk);
		$display("errors: value %0d control %0d run %0d; zero clamps %0d wraps %0d gaps %0d",
			value_errs, ctrl_errs, run_errs, relu_zeros, slice_wraps, gap_windows);
		if (timed_out || (value_errs + ctrl_errs + run_errs) != 0) begin
			$display("sim failed");
		end else begin
			$display("sim passed");
		end
		$finish;
	end

endmodule

// File: tb.f
rtl/squeeze_pkg.sv
rtl/coeff_rom.sv
rtl/layer_sequencer.sv
rtl/mac_lane.sv
rtl/requant_relu.sv
rtl/squeeze_layer.sv
tb/squeeze_checker.sv
tb/tb_squeeze_layer.sv
